//--- bus_bridge.sv
`timescale 1ns/1ps

module bus_bridge (
    input  logic                   clk,
    input  logic                   rst,

    // cache side, read channel
    input  logic                   rd_req,
    input  logic [2:0]             rd_type,
    input  dcache_pkg::addr_t      rd_addr,
    output logic                   rd_rdy,
    output logic                   ret_valid,
    output logic                   ret_last,
    output dcache_pkg::line_t      ret_data,

    // cache side, write channel
    input  logic                   wr_req,
    input  logic [2:0]             wr_type,
    input  dcache_pkg::addr_t      wr_addr,
    input  dcache_pkg::line_strb_t wr_wstrb,
    input  dcache_pkg::line_t      wr_data,
    output logic                   wr_rdy,

    // memory port
    output logic                   mem_req_valid,
    output dcache_pkg::mem_req_t   mem_req,
    input  logic                   mem_req_ready,
    input  logic                   mem_rsp_valid,
    input  dcache_pkg::line_t      mem_rsp_data
);
    import dcache_pkg::*;

    logic       slot_full;    // one request waiting for the memory port
    mem_req_t   slot;
    logic       rd_pending;   // line read issued, response not back yet
    logic       rd_fire;
    logic       wr_fire;
    logic       mem_fire;
    logic [2:0] acc_type;
    addr_t      acc_addr;
    mem_req_t   slot_d;

    // word writes only go out with strobes
    function automatic line_strb_t type_strb(logic [2:0] t, line_strb_t strb);
        return (t == ACC_WORD) ? strb : '0;
    endfunction

    assign rd_rdy = ~slot_full & ~rd_pending;
    assign wr_rdy = ~slot_full;

    assign rd_fire  = rd_req & rd_rdy;
    assign wr_fire  = wr_req & wr_rdy;
    assign mem_fire = mem_req_valid & mem_req_ready;

    // cache issues at most one of the two in a cycle
    assign acc_type = wr_req ? wr_type : rd_type;
    assign acc_addr = wr_req ? wr_addr : rd_addr;

    always_comb begin
        slot_d.we   = wr_req;
        slot_d.addr = acc_addr & ~addr_t'(LINE_BYTES - 1);  // line aligned
        slot_d.strb = wr_req ? type_strb(acc_type, wr_wstrb) : '0;
        slot_d.data = wr_req ? wr_data : '0;  // reads fetch the whole line
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_full <= 1'b0;
        end else if (rd_fire | wr_fire) begin
            slot_full <= 1'b1;
        end else if (mem_fire) begin
            slot_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire | wr_fire) begin
            slot <= slot_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending <= 1'b0;
        end else begin
            if (mem_rsp_valid) begin
                rd_pending <= 1'b0;
            end
            if (mem_fire & ~slot.we) begin
                rd_pending <= 1'b1;
            end
        end
    end

    assign mem_req_valid = slot_full;
    assign mem_req       = slot;

    // one response per read, returned as a single last beat
    assign ret_valid = mem_rsp_valid;
    assign ret_last  = mem_rsp_valid;
    assign ret_data  = mem_rsp_data;

endmodule

//--- cpu_req_buffer.sv
`timescale 1ns/1ps

module cpu_req_buffer (
    input  logic                clk,
    input  logic                rst,

    // cpu side
    input  logic                cpu_req_valid,
    input  dcache_pkg::cpu_req_t cpu_req,
    output logic                cpu_req_ready,

    // cache side
    input  logic                data_ok,
    output logic                valid,
    output logic                op,
    output logic [19:0]         tag,
    output logic [7:0]          index,
    output logic [3:0]          offset,
    output dcache_pkg::wstrb_t  wstrb,
    output dcache_pkg::word_t   wdata
);
    import dcache_pkg::*;

    logic     full;    // entry holds a live access
    cpu_req_t req_q;   // registered request
    logic     accept;

    // ready only while empty, so one access is in flight at a time
    assign cpu_req_ready = ~full;
    assign accept        = cpu_req_valid & cpu_req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (data_ok) begin
            full <= 1'b0;  // cache finished the access
        end
    end

    // payload only, held steady until data_ok
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req;
        end
    end

    assign valid  = full;
    assign op     = req_q.op;
    assign tag    = req_q.addr[31:12];
    assign index  = req_q.addr[11:4];
    assign offset = req_q.addr[3:0];
    assign wstrb  = req_q.wstrb;
    assign wdata  = req_q.wdata;

endmodule

//--- dcache_pkg.sv
package dcache_pkg;

    // widths that carry a meaning
    typedef logic [31:0]  addr_t;       // byte address
    typedef logic [31:0]  word_t;       // cpu data word
    typedef logic [3:0]   wstrb_t;      // cpu byte strobes
    typedef logic [127:0] line_t;       // bus data line
    typedef logic [15:0]  line_strb_t;  // line byte strobes

    localparam int LINE_BYTES = 16;        // bytes per bus line
    localparam logic [2:0] ACC_WORD = 3'b010;  // access type code, word

    // one cpu load or store
    typedef struct packed {
        logic   op;     // 1 write, 0 read
        addr_t  addr;
        wstrb_t wstrb;
        word_t  wdata;
    } cpu_req_t;

    // one request on the external memory port
    typedef struct packed {
        logic       we;    // 1 write, 0 line read
        addr_t      addr;  // line aligned
        line_strb_t strb;  // zero on reads
        line_t      data;
    } mem_req_t;

endpackage

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rst,

    // cpu side
    input  logic                 cpu_req_valid,
    input  dcache_pkg::cpu_req_t cpu_req,
    output logic                 cpu_req_ready,
    output logic                 cpu_resp_valid,
    output dcache_pkg::word_t    cpu_rdata,

    // memory side
    output logic                 mem_req_valid,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    input  dcache_pkg::line_t    mem_rsp_data
);
    import dcache_pkg::*;

    // buffer to cache
    logic        valid;
    logic        op;
    logic [19:0] tag;
    logic [7:0]  index;
    logic [3:0]  offset;
    wstrb_t      wstrb;
    word_t       wdata;
    logic        data_ok;
    word_t       rdata;

    // cache to bridge
    logic        rd_req;
    logic [2:0]  rd_type;
    addr_t       rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    line_t       ret_data;
    logic        wr_req;
    logic [2:0]  wr_type;
    addr_t       wr_addr;
    line_strb_t  wr_wstrb;
    line_t       wr_data;
    logic        wr_rdy;

    assign cpu_resp_valid = data_ok;  // cpu always takes the response
    assign cpu_rdata      = rdata;

    cpu_req_buffer req_buf_i (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .cpu_req_ready (cpu_req_ready),
        .data_ok       (data_ok),
        .valid         (valid),
        .op            (op),
        .tag           (tag),
        .index         (index),
        .offset        (offset),
        .wstrb         (wstrb),
        .wdata         (wdata)
    );

    // addr_ok has no user, the buffer holds until data_ok
    dummy_dcache dcache_i (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .op        (op),
        .tag       (tag),
        .index     (index),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_type   (wr_type),
        .wr_addr   (wr_addr),
        .wr_wstrb  (wr_wstrb),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    bus_bridge bridge_i (
        .clk           (clk),
        .rst           (rst),
        .rd_req        (rd_req),
        .rd_type       (rd_type),
        .rd_addr       (rd_addr),
        .rd_rdy        (rd_rdy),
        .ret_valid     (ret_valid),
        .ret_last      (ret_last),
        .ret_data      (ret_data),
        .wr_req        (wr_req),
        .wr_type       (wr_type),
        .wr_addr       (wr_addr),
        .wr_wstrb      (wr_wstrb),
        .wr_data       (wr_data),
        .wr_rdy        (wr_rdy),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

endmodule

//--- dummy_dcache.sv
`timescale 1ns/1ps

module dummy_dcache (
    input  logic                   clk,
    input  logic                   rst,

    // pipeline side
    input  logic                   valid,
    input  logic                   op,      // 1 write, 0 read
    input  logic [19:0]            tag,
    input  logic [7:0]             index,
    input  logic [3:0]             offset,
    input  dcache_pkg::wstrb_t     wstrb,
    input  dcache_pkg::word_t      wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output dcache_pkg::word_t      rdata,

    // bus side, read channel
    output logic                   rd_req,
    output logic [2:0]             rd_type,
    output dcache_pkg::addr_t      rd_addr,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  dcache_pkg::line_t      ret_data,

    // bus side, write channel
    output logic                   wr_req,
    output logic [2:0]             wr_type,
    output dcache_pkg::addr_t      wr_addr,
    output dcache_pkg::line_strb_t wr_wstrb,
    output dcache_pkg::line_t      wr_data,
    input  logic                   wr_rdy
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        READ_REQ,
        READ_WAIT,
        WRITE_REQ
    } state_t;

    state_t state;
    state_t next_state;

    addr_t  cpu_addr;
    logic   [1:0] lane;    // word position inside the line
    logic   rd_fire;
    logic   wr_fire;
    logic   rd_done;

    assign cpu_addr = {tag, index, offset};
    assign lane     = cpu_addr[3:2];

    assign rd_fire = (state == READ_REQ) & rd_rdy;
    assign wr_fire = (state == WRITE_REQ) & wr_rdy;
    assign rd_done = (state == READ_WAIT) & ret_valid & ret_last;  // single beat

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    next_state = op ? WRITE_REQ : READ_REQ;
                end
            end
            READ_REQ: begin
                if (rd_rdy) begin
                    next_state = READ_WAIT;  // request taken this cycle
                end
            end
            READ_WAIT: begin
                if (rd_done) begin
                    next_state = IDLE;
                end
            end
            WRITE_REQ: begin
                if (wr_rdy) begin
                    next_state = IDLE;  // posted, no response awaited
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // read request, unaligned address, bridge widens it to a line
    assign rd_req  = rd_fire;
    assign rd_type = ACC_WORD;
    assign rd_addr = rd_fire ? cpu_addr : '0;

    // write request with data and strobes moved into their lane
    assign wr_type = ACC_WORD;

    always_comb begin
        wr_req   = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        wr_wstrb = '0;
        if (wr_fire) begin
            wr_req   = 1'b1;
            wr_addr  = cpu_addr;  // offset kept for the lane
            wr_data  = line_t'(wdata) << {lane, 5'b0};
            wr_wstrb = line_strb_t'(wstrb) << {lane, 2'b0};
        end
    end

    // responses to the pipeline
    assign addr_ok = rd_fire | wr_fire;  // request handed to the bus
    assign data_ok = rd_done | wr_fire;
    assign rdata   = rd_done ? ret_data[lane*32 +: 32] : '0;

endmodule

//--- run.sh
#!/bin/sh
# compile and run the dcache testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dcache_top -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dcache_top 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- sim.f
dcache_pkg.sv
cpu_req_buffer.sv
dummy_dcache.sv
bus_bridge.sv
dcache_top.sv
tb_clk_gen.sv
tb_mem_model.sv
tb_dcache_top.sv

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);  // reset held for 10 cycles
        #1 rst = 1'b0;
    end

endmodule

//--- tb_dcache_top.sv
`timescale 1ns/1ps

module tb_dcache_top;
    import dcache_pkg::*;

    logic        clk;
    logic        rst;
    logic        cpu_req_valid;
    cpu_req_t    cpu_req;
    logic        cpu_req_ready;
    logic        cpu_resp_valid;
    word_t       cpu_rdata;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_req_ready;
    logic        mem_rsp_valid;
    line_t       mem_rsp_data;

    logic [7:0]  ref_mem [0:4095];  // byte-wide reference memory
    cpu_req_t    steps [$];         // access table
    mem_req_t    mem_expect [$];    // memory requests not seen yet
    logic [31:0] rnd;
    int          resp_count;
    logic        table_ready = 1'b0;

    tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    tb_mem_model mem_i (
        .clk           (clk),
        .rst           (rst),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    dcache_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req        (cpu_req),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_rdata      (cpu_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [127:0] got,
                         input logic [127:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic add_access(input logic op, input addr_t addr, input wstrb_t wstrb,
                              input word_t wdata);
        cpu_req_t r;
        r.op    = op;
        r.addr  = addr;
        r.wstrb = wstrb;
        r.wdata = wdata;
        steps.push_back(r);
    endtask

    task automatic build_table();
        addr_t  a;
        wstrb_t s;
        for (int i = 0; i < 4; i++) begin  // every lane of three lines
            add_access(1'b0, 32'h0000_0000 + i * 4, 4'h0, 32'h0);
            add_access(1'b0, 32'h0000_03a0 + i * 4, 4'h0, 32'h0);
            add_access(1'b0, 32'h1234_5ff0 + i * 4, 4'h0, 32'h0);
        end
        add_access(1'b1, 32'h0000_03a4, 4'hf, 32'hdead_beef);
        for (int i = 0; i < 4; i++) begin
            add_access(1'b0, 32'h0000_03a0 + i * 4, 4'h0, 32'h0);  // written lane and neighbours
        end
        add_access(1'b1, 32'h0000_0510, 4'b0001, 32'h1122_33aa);
        add_access(1'b0, 32'h0000_0510, 4'h0, 32'h0);
        add_access(1'b1, 32'h0000_0514, 4'b0110, 32'h55cc_dd66);
        add_access(1'b0, 32'h0000_0514, 4'h0, 32'h0);
        add_access(1'b1, 32'h0000_051c, 4'b1000, 32'hee00_0077);
        add_access(1'b0, 32'h0000_051c, 4'h0, 32'h0);
        add_access(1'b0, 32'h0000_0518, 4'h0, 32'h0);
        for (int i = 0; i < 32; i++) begin  // random mix over four lines
            rnd = xorshift(rnd);
            a   = {20'h0, 6'b100000, rnd[5:2], 2'b00};
            s   = (rnd[11:8] == 4'h0) ? 4'hf : rnd[11:8];
            add_access(rnd[16], a, s, xorshift(rnd ^ 32'h0000_1000));
        end
    endtask

    function automatic word_t ref_word(input addr_t addr);
        int a;
        a = int'(addr[11:2]) * 4;
        return {ref_mem[a + 3], ref_mem[a + 2], ref_mem[a + 1], ref_mem[a]};
    endfunction

    // line-aligned request with the word placed in lane addr[3:2]
    function automatic mem_req_t mem_req_for(input cpu_req_t r);
        mem_req_t m;
        int       lane;
        lane   = int'(r.addr[3:2]);
        m.we   = r.op;
        m.addr = {r.addr[31:4], 4'h0};
        m.strb = '0;
        m.data = '0;
        if (r.op) begin
            for (int k = 0; k < 4; k++) begin
                m.strb[lane*4 + k] = r.wstrb[k];
                if (r.wstrb[k]) begin
                    m.data[lane*32 + k*8 +: 8] = r.wdata[k*8 +: 8];
                end
            end
        end
        return m;
    endfunction

    task automatic check_idle_outputs();
        check("cpu_resp_valid", 128'(cpu_resp_valid), 128'(0));
        check("mem_req_valid", 128'(mem_req_valid), 128'(0));
        check("cpu_req_ready", 128'(cpu_req_ready), 128'(1));
    endtask

    task automatic run_access(input cpu_req_t req);
        word_t expected;
        int    a;
        expected = ref_word(req.addr);
        mem_expect.push_back(mem_req_for(req));
        cpu_req_valid = 1'b1;
        cpu_req       = req;
        @(negedge clk);
        while (!cpu_req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);  // accepted here
        #1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        @(negedge clk);
        while (!cpu_resp_valid) begin
            check("cpu_req_ready", 128'(cpu_req_ready), 128'(0));
            @(negedge clk);
        end
        check("cpu_req_ready", 128'(cpu_req_ready), 128'(0));
        if (!req.op) begin
            check("cpu_rdata", 128'(cpu_rdata), 128'(expected));
        end else begin
            a = int'(req.addr[11:2]) * 4;
            for (int k = 0; k < 4; k++) begin
                if (req.wstrb[k]) begin
                    ref_mem[a + k] = req.wdata[k*8 +: 8];
                end
            end
        end
        @(posedge clk);
        #1;
    endtask

    // memory port format and response count
    initial begin
        mem_req_t got;
        mem_req_t exp;
        resp_count = 0;
        forever begin
            @(negedge clk);
            if (!rst && cpu_resp_valid) begin
                resp_count++;
            end
            if (!rst && mem_req_valid && mem_req_ready) begin
                if (mem_expect.size() == 0) begin
                    $display("memory request seen with no access waiting for one");
                    $display("TEST FAIL");
                    $fatal(1, "unexpected memory request");
                end
                got = mem_req;
                exp = mem_expect.pop_front();
                check("mem_req.addr[3:0]", 128'(got.addr[3:0]), 128'(0));
                check("mem_req.we", 128'(got.we), 128'(exp.we));
                check("mem_req.addr", 128'(got.addr), 128'(exp.addr));
                check("mem_req.strb", 128'(got.strb), 128'(exp.strb));
                for (int b = 0; b < 16; b++) begin
                    if (!got.strb[b]) begin
                        got.data[b*8 +: 8] = 8'h00;  // only enabled bytes matter
                    end
                end
                check("mem_req.data", got.data, exp.data);
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (steps.size() * 200 + 40) @(posedge clk);
        $display("watchdog expired, the access table did not finish in time");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        rnd           = 32'h5f5b_0a77;
        for (int a = 0; a < 4096; a += 4) begin
            for (int k = 0; k < 4; k++) begin
                ref_mem[a + k] = 8'(xorshift(32'h5f5b_0a77 ^ a) >> (k * 8));
            end
        end
        build_table();
        table_ready = 1'b1;

        @(negedge clk);
        while (rst) begin
            check_idle_outputs();
            @(negedge clk);
        end
        check_idle_outputs();  // first cycle out of reset
        @(posedge clk);
        #1;

        for (int i = 0; i < steps.size(); i++) begin
            run_access(steps[i]);
            rnd = xorshift(rnd);
            repeat (rnd[1:0]) begin  // idle gap on the cpu side
                @(posedge clk);
                #1;
            end
        end

        while (mem_expect.size() != 0) begin  // last posted write
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        check("response count", 128'(resp_count), 128'(steps.size()));
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_req_valid,
    input  dcache_pkg::mem_req_t mem_req,
    output logic                 mem_req_ready,
    output logic                 mem_rsp_valid,
    output dcache_pkg::line_t    mem_rsp_data
);
    import dcache_pkg::*;

    line_t       mem [0:255];  // 4 KB, upper address bits alias
    logic [31:0] rnd;
    logic        fire;
    mem_req_t    req;
    logic        rsp_pending;
    logic [1:0]  rsp_wait;     // cycles left before the response
    line_t       rsp_line;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        // same fill as the reference memory, keyed by byte address
        for (int l = 0; l < 256; l++) begin
            for (int w = 0; w < 4; w++) begin
                mem[l][w*32 +: 32] = xorshift(32'h5f5b_0a77 ^ (l * 16 + w * 4));
            end
        end
        rnd           = 32'h5f5b_0a77;
        rsp_pending   = 1'b0;
        rsp_wait      = 2'd0;
        rsp_line      = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        forever begin
            @(negedge clk);
            fire = mem_req_valid & mem_req_ready & ~rst;  // transfer at next edge
            req  = mem_req;
            @(posedge clk);
            #1;
            if (fire && req.we) begin
                for (int b = 0; b < 16; b++) begin
                    if (req.strb[b]) begin
                        mem[req.addr[11:4]][b*8 +: 8] = req.data[b*8 +: 8];
                    end
                end
            end else if (fire) begin
                rsp_line    = mem[req.addr[11:4]];
                rnd         = xorshift(rnd);
                rsp_wait    = rnd[1:0];  // 0 to 3 idle cycles
                rsp_pending = 1'b1;
            end
            mem_rsp_valid = 1'b0;
            if (rsp_pending && rsp_wait == 2'd0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = rsp_line;
                rsp_pending   = 1'b0;
            end else if (rsp_pending) begin
                rsp_wait = rsp_wait - 2'd1;
            end
            rnd           = xorshift(rnd);
            mem_req_ready = (rnd[3:2] != 2'b00);  // stall about one cycle in four
        end
    end

endmodule
